// ==== source/datapath_config.svh ====
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// Register and bus width
`define DATA_WIDTH 32

// General register file
`define REG_COUNT 16
`define REG_INDEX_WIDTH 4

// Instruction word fields
`define OPCODE_WIDTH 5
`define IMM_WIDTH 19

// Shift amount taken from the low bits of rc
`define SHAMT_WIDTH 5

// Queue entries, also the initial credits of the source
`define QUEUE_DEPTH 4
`define QUEUE_PTR_WIDTH 2

// Credit and occupancy counters, must hold QUEUE_DEPTH
`define CREDIT_WIDTH 3

`endif

// ==== source/isaPkg.sv ====
`include "datapath_config.svh"

package isaPkg;

        typedef enum logic [`OPCODE_WIDTH-1:0] {
                OP_LDI = 5'b00001,
                OP_ADD = 5'b00011,
                OP_SUB = 5'b00100,
                OP_AND = 5'b00101,
                OP_OR  = 5'b00110,
                OP_SHR = 5'b00111,
                OP_SHL = 5'b01001,
                OP_NOT = 5'b10010
        } opcode_t;

        // Immediate is {rc, immLow}
        typedef struct packed {
                opcode_t                                opcode; // Bits 31-27
                logic [`REG_INDEX_WIDTH-1:0]            ra;     // Destination
                logic [`REG_INDEX_WIDTH-1:0]            rb;     // First source
                logic [`REG_INDEX_WIDTH-1:0]            rc;     // Second source
                logic [`IMM_WIDTH-`REG_INDEX_WIDTH-1:0] immLow;
        } instrFields_t;

        function automatic logic isLegalOpcode(logic [`OPCODE_WIDTH-1:0] code);
                logic legal;
                case (code)
                        OP_LDI, OP_ADD, OP_SUB, OP_AND,
                        OP_OR, OP_SHR, OP_SHL, OP_NOT: legal = 1'b1;
                        default: legal = 1'b0;
                endcase
                return legal;
        endfunction

endpackage

// ==== source/pipePkg.sv ====
`include "datapath_config.svh"

package pipePkg;

        import isaPkg::*;

        // Queue payload
        typedef struct packed {
                opcode_t                     opcode;
                logic                        illegal; // Code outside opcode_t
                logic [`REG_INDEX_WIDTH-1:0] ra;
                logic [`REG_INDEX_WIDTH-1:0] rb;
                logic [`REG_INDEX_WIDTH-1:0] rc;
                logic [`DATA_WIDTH-1:0]      imm;     // Already extended
        } microOp_t;

        typedef struct packed {
                logic [`REG_INDEX_WIDTH-1:0] regIndex;
                logic [`DATA_WIDTH-1:0]      value;
        } writeBack_t;

        // Execution steps, one per cycle
        typedef enum logic [1:0] {
                STEP_IDLE,
                STEP_LOADY,
                STEP_ALUZ,
                STEP_WRITE
        } execState_t;

endpackage

// ==== source/instrDecoder.sv ====
`timescale 1ns/10ps

`include "datapath_config.svh"

module instrDecoder
        import isaPkg::*;
        import pipePkg::*;
(
        input  logic                   Clock,
        input  logic                   rstN,
        input  logic                   instrValid,
        input  logic [`DATA_WIDTH-1:0] instrWord,
        output logic                   pushValid,
        output microOp_t               pushOp
);

        instrFields_t fields;
        microOp_t     decodedOp;

        assign fields = instrFields_t'(instrWord);

        always_comb begin
                decodedOp.opcode  = fields.opcode;
                decodedOp.illegal = !isLegalOpcode(fields.opcode);
                decodedOp.ra      = fields.ra;
                decodedOp.rb      = fields.rb;
                decodedOp.rc      = fields.rc;
                // Zero-extended immediate
                decodedOp.imm     = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, fields.rc, fields.immLow};
        end

        // One cycle in the decoder register
        always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        pushValid <= 1'b0;
                end else begin
                        pushValid <= instrValid;
                end
        end

        always_ff @(posedge Clock) begin
                if (instrValid) begin
                        pushOp <= decodedOp;
                end
        end

endmodule

// ==== source/microOpQueue.sv ====
`timescale 1ns/10ps

`include "datapath_config.svh"

module microOpQueue
        import pipePkg::*;
(
        input  logic     Clock,
        input  logic     rstN,
        input  logic     pushValid,
        input  microOp_t pushOp,
        input  logic     pop,
        output logic     headValid,
        output microOp_t head,
        output logic     creditReturn
);

        microOp_t                    mem [`QUEUE_DEPTH];
        logic [`QUEUE_PTR_WIDTH-1:0] wrPtr;
        logic [`QUEUE_PTR_WIDTH-1:0] rdPtr;
        logic [`CREDIT_WIDTH-1:0]    count; // Occupancy
        logic                        popFire;

        function automatic logic [`QUEUE_PTR_WIDTH-1:0] nextPtr(
                logic [`QUEUE_PTR_WIDTH-1:0] ptr
        );
                logic [`QUEUE_PTR_WIDTH-1:0] result;
                if (ptr == (`QUEUE_PTR_WIDTH)'(`QUEUE_DEPTH - 1)) begin
                        result = '0;
                end else begin
                        result = ptr + 1'b1;
                end
                return result;
        endfunction

        assign headValid = (count != '0);
        assign head      = mem[rdPtr];
        assign popFire   = pop && headValid;

        // Credits guarantee room, so every push lands
        always_ff @(posedge Clock) begin
                if (pushValid) begin
                        mem[wrPtr] <= pushOp;
                end
        end

        always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        wrPtr        <= '0;
                        rdPtr        <= '0;
                        count        <= '0;
                        creditReturn <= 1'b0;
                end else begin
                        creditReturn <= popFire; // One credit per pop
                        if (pushValid) begin
                                wrPtr <= nextPtr(wrPtr);
                        end
                        if (popFire) begin
                                rdPtr <= nextPtr(rdPtr);
                        end
                        case ({pushValid, popFire})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

endmodule

// ==== source/execDatapath.sv ====
`timescale 1ns/10ps

`include "datapath_config.svh"

module execDatapath
        import isaPkg::*;
        import pipePkg::*;
(
        input  logic       Clock,
        input  logic       rstN,
        input  logic       headValid,
        input  microOp_t   head,
        output logic       pop,
        output logic       wbValid,
        output writeBack_t wbData,
        output logic       illegalOp
);

        logic [`DATA_WIDTH-1:0]      regFile [`REG_COUNT];
        logic [`DATA_WIDTH-1:0]      yReg;
        logic [`DATA_WIDTH-1:0]      zReg;
        logic [`DATA_WIDTH-1:0]      busData;
        logic [`DATA_WIDTH-1:0]      aluResult;
        logic [`REG_INDEX_WIDTH-1:0] busSel;
        logic [`SHAMT_WIDTH-1:0]     shamt;
        microOp_t                    curOp;
        execState_t                  state;
        execState_t                  nextState;

        assign pop       = (state == STEP_IDLE) && headValid;
        assign illegalOp = pop && head.illegal; // Dropped in the pop cycle
        assign wbValid   = (state == STEP_WRITE);

        assign wbData.regIndex = curOp.ra;
        assign wbData.value    = zReg;

        // Operand bus, one source per step
        always_comb begin
                busSel = (state == STEP_LOADY) ? curOp.rb : curOp.rc;
                if (state == STEP_WRITE) begin
                        busData = zReg; // Z drives the bus on write
                end else begin
                        busData = regFile[busSel];
                end
        end

        assign shamt = busData[`SHAMT_WIDTH-1:0];

        always_comb begin
                case (curOp.opcode)
                        OP_ADD:  aluResult = yReg + busData;
                        OP_SUB:  aluResult = yReg - busData;
                        OP_AND:  aluResult = yReg & busData;
                        OP_OR:   aluResult = yReg | busData;
                        OP_SHL:  aluResult = yReg << shamt;
                        OP_SHR:  aluResult = yReg >> shamt;
                        OP_NOT:  aluResult = ~yReg;
                        default: aluResult = yReg;
                endcase
        end

        always_comb begin
                nextState = state;
                case (state)
                        STEP_IDLE: begin
                                if (pop && !head.illegal) begin
                                        if (head.opcode == OP_LDI) begin
                                                nextState = STEP_WRITE; // Skip Y and ALU
                                        end else begin
                                                nextState = STEP_LOADY;
                                        end
                                end
                        end
                        STEP_LOADY: nextState = STEP_ALUZ;
                        STEP_ALUZ:  nextState = STEP_WRITE;
                        STEP_WRITE: nextState = STEP_IDLE;
                        default:    nextState = STEP_IDLE;
                endcase
        end

        always_ff @(posedge Clock) begin
                if (pop) begin
                        curOp <= head;
                end
        end

        always_ff @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        state <= STEP_IDLE;
                        yReg  <= '0;
                        zReg  <= '0;
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                regFile[i] <= '0;
                        end
                end else begin
                        state <= nextState;
                        case (state)
                                STEP_IDLE: begin
                                        if (pop && !head.illegal && head.opcode == OP_LDI) begin
                                                zReg <= head.imm;
                                        end
                                end
                                STEP_LOADY: yReg <= busData;
                                STEP_ALUZ:  zReg <= aluResult;
                                STEP_WRITE: regFile[curOp.ra] <= busData;
                                default: ;
                        endcase
                end
        end

endmodule

// ==== source/datapathTop.sv ====
`timescale 1ns/10ps

`include "datapath_config.svh"

module datapathTop
        import pipePkg::*;
(
        input  logic                   Clock,
        input  logic                   rstN,
        input  logic                   instrValid,
        input  logic [`DATA_WIDTH-1:0] instrWord,
        output logic                   instrCredit,
        output logic                   wbValid,
        output writeBack_t             wbData,
        output logic                   illegalOp
);

        logic     pushValid;
        microOp_t pushOp;
        logic     headValid;
        microOp_t head;
        logic     pop;

        instrDecoder decoder (
                .Clock      (Clock),
                .rstN       (rstN),
                .instrValid (instrValid),
                .instrWord  (instrWord),
                .pushValid  (pushValid),
                .pushOp     (pushOp)
        );

        microOpQueue queue (
                .Clock        (Clock),
                .rstN         (rstN),
                .pushValid    (pushValid),
                .pushOp       (pushOp),
                .pop          (pop),
                .headValid    (headValid),
                .head         (head),
                .creditReturn (instrCredit) // Back to the source
        );

        execDatapath exec (
                .Clock     (Clock),
                .rstN      (rstN),
                .headValid (headValid),
                .head      (head),
                .pop       (pop),
                .wbValid   (wbValid),
                .wbData    (wbData),
                .illegalOp (illegalOp)
        );

endmodule

// ==== verification/datapath_sva.sv ====
`timescale 1ns/10ps

`include "datapath_config.svh"

module datapathSva (
        input logic                     Clock,
        input logic                     rstN,
        input logic                     pushValid,
        input logic                     pop,
        input logic                     headValid,
        input logic [`CREDIT_WIDTH-1:0] count,
        input logic                     wbValid,
        input logic                     illegalOp
);

        int failCount = 0; // Read by the testbench

        occupancyBound: assert property (@(posedge Clock) disable iff (!rstN)
                count <= `QUEUE_DEPTH)
        else begin
                $error("Queue occupancy above depth");
                failCount++;
        end

        pushIntoFull: assert property (@(posedge Clock) disable iff (!rstN)
                pushValid |-> count < `QUEUE_DEPTH)
        else begin
                $error("Push into a full queue");
                failCount++;
        end

        resultExclusive: assert property (@(posedge Clock) disable iff (!rstN)
                !(wbValid && illegalOp))
        else begin
                $error("Write-back and illegal pulse in the same cycle");
                failCount++;
        end

        wbSinglePulse: assert property (@(posedge Clock) disable iff (!rstN)
                wbValid |=> !wbValid)
        else begin
                $error("Write-back held longer than one cycle");
                failCount++;
        end

        popNeedsHead: assert property (@(posedge Clock) disable iff (!rstN)
                pop |-> headValid)
        else begin
                $error("Pop without a valid head");
                failCount++;
        end

endmodule

// Queue side, no result outputs here
bind microOpQueue datapathSva queueChecks (
        .Clock     (Clock),
        .rstN      (rstN),
        .pushValid (pushValid),
        .pop       (pop),
        .headValid (headValid),
        .count     (count),
        .wbValid   (1'b0),
        .illegalOp (1'b0)
);

bind execDatapath datapathSva execChecks (
        .Clock     (Clock),
        .rstN      (rstN),
        .pushValid (1'b0),
        .pop       (pop),
        .headValid (headValid),
        .count     ('0),
        .wbValid   (wbValid),
        .illegalOp (illegalOp)
);

// ==== verification/datapathTb.sv ====
`timescale 1ns/10ps

`include "datapath_config.svh"

module datapathTb
        import isaPkg::*;
        import pipePkg::*;
();

        typedef struct packed {
                logic       illegal;
                writeBack_t wb;
        } expEvent_t;

        localparam logic [`OPCODE_WIDTH-1:0] BAD_CODES [4] =
                '{5'b00000, 5'b00010, 5'b01000, 5'b11111};
        localparam opcode_t ALU_CODES [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SHL, OP_SHR, OP_NOT};

        logic                   Clock;
        logic                   rstN;
        logic                   instrValid;
        logic [`DATA_WIDTH-1:0] instrWord;
        logic                   instrCredit;
        logic                   wbValid;
        writeBack_t             wbData;
        logic                   illegalOp;

        logic [`DATA_WIDTH-1:0] model [`REG_COUNT]; // Reference registers
        expEvent_t              expQ [$];
        string                  curTest;
        int                     credits;
        int                     creditPulses;
        int                     sentCount;
        int                     checkErrors;
        int                     errorBase;
        int                     pulseBase;
        int                     testsPassed;
        int                     testsFailed;

        datapathTop u_dut (
                .Clock       (Clock),
                .rstN        (rstN),
                .instrValid  (instrValid),
                .instrWord   (instrWord),
                .instrCredit (instrCredit),
                .wbValid     (wbValid),
                .wbData      (wbData),
                .illegalOp   (illegalOp)
        );

        initial Clock = 1'b0;
        always #20 Clock = ~Clock;

        // Source side credit count
        always @(posedge Clock or negedge rstN) begin
                if (!rstN) begin
                        credits      <= `QUEUE_DEPTH;
                        creditPulses <= 0;
                end else begin
                        credits <= credits + int'(instrCredit) - int'(instrValid);
                        if (instrCredit) begin
                                creditPulses <= creditPulses + 1;
                        end
                end
        end

        // Results are stable at the falling edge
        always @(negedge Clock) begin
                expEvent_t exp;
                if (rstN && (wbValid || illegalOp)) begin
                        assert (expQ.size() != 0) else begin
                                $display("Error in %s: result came out with none expected",
                                         curTest);
                                checkErrors++;
                        end
                        if (expQ.size() != 0) begin
                                exp = expQ.pop_front();
                                assert (exp.illegal == illegalOp && (illegalOp || wbData == exp.wb))
                                else begin
                                        if (exp.illegal) begin
                                                $display(
                                                        "Fail %s: expected illegalOp, actual r%0d=%h",
                                                        curTest, wbData.regIndex, wbData.value);
                                        end else begin
                                                $display(
                                                        "Fail %s: expected r%0d=%h, actual %s r%0d=%h",
                                                        curTest, exp.wb.regIndex, exp.wb.value,
                                                        illegalOp ? "illegalOp" : "write-back",
                                                        wbData.regIndex, wbData.value);
                                        end
                                        checkErrors++;
                                end
                        end
                end
        end

        function automatic int svaFailures();
                return u_dut.queue.queueChecks.failCount + u_dut.exec.execChecks.failCount;
        endfunction

        function automatic logic [`DATA_WIDTH-1:0] instrBits(
                logic [4:0] code, int ra, int rb, int rc
        );
                return {code, 4'(ra), 4'(rb), 4'(rc), 15'b0};
        endfunction

        function automatic logic [`DATA_WIDTH-1:0] ldiWord(int ra, logic [18:0] imm);
                return {OP_LDI, 4'(ra), 4'b0, imm}; // rb field unused
        endfunction

        // Expected result of one word, updates the reference registers
        function automatic expEvent_t predict(logic [`DATA_WIDTH-1:0] word);
                expEvent_t              exp;
                logic [`DATA_WIDTH-1:0] y;
                logic [`DATA_WIDTH-1:0] c;
                y = model[word[22:19]];
                c = model[word[18:15]];
                exp = '0;
                exp.wb.regIndex = word[26:23];
                case (word[31:27])
                        OP_LDI:  exp.wb.value = {13'b0, word[18:0]};
                        OP_ADD:  exp.wb.value = y + c;
                        OP_SUB:  exp.wb.value = y - c;
                        OP_AND:  exp.wb.value = y & c;
                        OP_OR:   exp.wb.value = y | c;
                        OP_SHL:  exp.wb.value = y << c[4:0];
                        OP_SHR:  exp.wb.value = y >> c[4:0];
                        OP_NOT:  exp.wb.value = ~y;
                        default: exp.illegal = 1'b1;
                endcase
                if (!exp.illegal) begin
                        model[exp.wb.regIndex] = exp.wb.value;
                end
                return exp;
        endfunction

        task automatic idleCycles(int n);
                repeat (n) begin
                        @(posedge Clock);
                        #2;
                end
        endtask

        task automatic sendWord(logic [`DATA_WIDTH-1:0] word);
                int waited;
                waited = 0;
                while (credits == 0 && waited < 100) begin
                        idleCycles(1);
                        waited++;
                end
                if (credits == 0) begin
                        $display("Timeout in %s: no credit came back to send an instruction",
                                 curTest);
                        checkErrors++;
                end else begin
                        expQ.push_back(predict(word));
                        instrValid = 1'b1;
                        instrWord  = word;
                        idleCycles(1);
                        instrValid = 1'b0;
                        sentCount++;
                end
        endtask

        task automatic startTest(string name);
                curTest   = name;
                errorBase = checkErrors + svaFailures();
                pulseBase = creditPulses;
                sentCount = 0;
        endtask

        task automatic finishTest();
                int waited;
                int errs;
                waited = 0;
                while ((expQ.size() != 0 || credits != `QUEUE_DEPTH) && waited < 2000) begin
                        idleCycles(1);
                        waited++;
                end
                if (expQ.size() != 0) begin
                        $display("Timeout in %s: %0d results never came out", curTest, expQ.size());
                        checkErrors++;
                        expQ.delete();
                end else if (credits != `QUEUE_DEPTH) begin
                        $display("Timeout in %s: credits did not all come back", curTest);
                        checkErrors++;
                end
                assert (creditPulses - pulseBase == sentCount) else begin
                        $display("Fail %s: expected %0d credit pulses, actual %0d",
                                 curTest, sentCount, creditPulses - pulseBase);
                        checkErrors++;
                end
                errs = checkErrors + svaFailures() - errorBase;
                $display("Test %s %s, %0d errors", curTest,
                         errs == 0 ? "passed" : "failed", errs);
                if (errs == 0) begin
                        testsPassed++;
                end else begin
                        testsFailed++;
                end
        endtask

        initial begin
                logic [`DATA_WIDTH-1:0] word;
                rstN        = 1'b0;
                instrValid  = 1'b0;
                instrWord   = '0;
                checkErrors = 0;
                testsPassed = 0;
                testsFailed = 0;
                curTest     = "reset";
                for (int i = 0; i < `REG_COUNT; i++) begin
                        model[i] = '0;
                end
                void'($urandom(32'hda44e792));
                repeat (2) @(posedge Clock);
                #2;
                rstN = 1'b1;

                startTest("load");
                repeat (5) begin
                        @(negedge Clock);
                        assert (!instrCredit && !wbValid && !illegalOp) else begin
                                $display("Error in load: an output pulsed before any instruction");
                                checkErrors++;
                        end
                end
                idleCycles(1);
                for (int i = 0; i < `REG_COUNT; i++) begin
                        sendWord(ldiWord(i, 19'h40000 | 19'(i * 'h1357))); // Bit 18 set
                end
                finishTest();

                startTest("alu");
                sendWord(ldiWord(1, 19'h0f0f0));
                sendWord(ldiWord(2, 19'h12345));
                sendWord(ldiWord(3, 19'h00022));
                sendWord(ldiWord(7, 19'h00024));
                sendWord(ldiWord(5, 19'h00023)); // Shift by 3
                sendWord(ldiWord(6, 19'h3c3c3));
                sendWord(instrBits(OP_ADD, 8, 1, 2));
                sendWord(instrBits(OP_SUB, 4, 3, 7));
                sendWord(instrBits(OP_AND, 9, 1, 6));
                sendWord(instrBits(OP_OR, 10, 1, 2));
                sendWord(instrBits(OP_NOT, 11, 1, 0));
                sendWord(instrBits(OP_SHL, 12, 2, 5));
                sendWord(instrBits(OP_SHR, 13, 1, 5));
                finishTest();

                startTest("burst");
                for (int i = 0; i < 12; i++) begin
                        if (i % 3 == 0) begin
                                sendWord(ldiWord(i, 19'(i * 'h2b1d)));
                        end else begin
                                sendWord(instrBits(OP_ADD, i, i - 1, (i + 1) % 16));
                        end
                end
                finishTest();

                startTest("illegal");
                sendWord(ldiWord(1, 19'h00155));
                sendWord(instrBits(5'b11111, 2, 1, 1));
                sendWord(instrBits(OP_ADD, 2, 1, 1));
                sendWord(instrBits(5'b00000, 3, 2, 1));
                sendWord(instrBits(OP_SUB, 3, 2, 1));
                finishTest();

                startTest("random");
                for (int i = 0; i < 200; i++) begin
                        if ($urandom_range(0, 7) == 0) begin
                                word = instrBits(BAD_CODES[$urandom_range(0, 3)],
                                                 $urandom_range(0, 15),
                                                 $urandom_range(0, 15), $urandom_range(0, 15));
                        end else if ($urandom_range(0, 3) == 0) begin
                                word = ldiWord($urandom_range(0, 15), 19'($urandom));
                        end else begin
                                word = instrBits(ALU_CODES[$urandom_range(0, 6)],
                                                 $urandom_range(0, 15),
                                                 $urandom_range(0, 15), $urandom_range(0, 15));
                        end
                        sendWord(word);
                        idleCycles($urandom_range(0, 3));
                end
                finishTest();

                $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
                if (testsFailed == 0 && checkErrors == 0 && svaFailures() == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule

// ==== verilog.f ====
+incdir+source
source/isaPkg.sv
source/pipePkg.sv
source/instrDecoder.sv
source/microOpQueue.sv
source/execDatapath.sv
source/datapathTop.sv
verification/datapath_sva.sv
verification/datapathTb.sv

// ==== Bender.yml ====
package:
  name: datapath

sources:
  - include_dirs:
      - source
    files:
      - source/isaPkg.sv
      - source/pipePkg.sv
      - source/instrDecoder.sv
      - source/microOpQueue.sv
      - source/execDatapath.sv
      - source/datapathTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/datapath_sva.sv
      - verification/datapathTb.sv
